/* sources.f */
hdl/decodePkg.sv
hdl/controlUnit.sv
hdl/immExtender.sv
hdl/registerFile.sv
hdl/decodeStage.sv
bench/decodeGolden.sv
bench/decodeStageTb.sv

/* Bender.yml */
package:
  name: decode_stage

sources:
  - hdl/decodePkg.sv
  - hdl/controlUnit.sv
  - hdl/immExtender.sv
  - hdl/registerFile.sv
  - hdl/decodeStage.sv
  - target: test
    files:
      - bench/decodeGolden.sv
      - bench/decodeStageTb.sv

/* bench/decodeStageTb.sv */
module decodeStageTb;
   timeunit 1ns;
   timeprecision 100ps;

   localparam logic [31:0] seed        = 32'h8409c825;
   localparam time         halfPeriod  = 4ns;
   localparam time         edgeTimeout = 100ns;
   localparam int          randomCount = 600;

   logic        clk;
   logic        rst;
   logic [31:0] InstrD, PCD, PCPlus4D, ResultW;
   logic        RegWriteW;
   logic [4:0]  RdW;
   logic [31:0] RD1E, RD2E, PCE, ImmExtE, PCPlus4E;
   logic [4:0]  Rs1E, Rs2E, RdE;
   logic        RegWriteE, MemWriteE, JumpE, BranchE, ALUSrcE;
   logic [1:0]  ResultSrcE;
   logic [2:0]  ALUControlE;
   logic [31:0] expRD1E, expRD2E, expPCE, expImmExtE, expPCPlus4E;
   logic [4:0]  expRs1E, expRs2E, expRdE;
   logic        expRegWriteE, expMemWriteE, expJumpE, expBranchE, expALUSrcE;
   logic [1:0]  expResultSrcE;
   logic [2:0]  expALUControlE;
   logic [31:0] lcgState;
   logic [31:0] pc;
   logic        outputsZero;
   int          mismatchCount;
   int          otherCount;

   decodeStage dut0 (.*);
   decodeGolden model0 (.*);

   initial begin
      clk = 1'b0;
      forever #halfPeriod clk = ~clk;
   end

   task automatic reportMismatch(string name, logic [31:0] expected, logic [31:0] actual);
      mismatchCount++;
      $display("ERR t=%0t %s expected %h actual %h", $time, name, expected, actual);
   endtask

   // Every output against the model, one cycle after the inputs.
   assert property (@(posedge clk) RD1E === expRD1E)
      else reportMismatch("RD1E", $sampled(expRD1E), $sampled(RD1E));
   assert property (@(posedge clk) RD2E === expRD2E)
      else reportMismatch("RD2E", $sampled(expRD2E), $sampled(RD2E));
   assert property (@(posedge clk) PCE === expPCE)
      else reportMismatch("PCE", $sampled(expPCE), $sampled(PCE));
   assert property (@(posedge clk) ImmExtE === expImmExtE)
      else reportMismatch("ImmExtE", $sampled(expImmExtE), $sampled(ImmExtE));
   assert property (@(posedge clk) PCPlus4E === expPCPlus4E)
      else reportMismatch("PCPlus4E", $sampled(expPCPlus4E), $sampled(PCPlus4E));
   assert property (@(posedge clk) Rs1E === expRs1E)
      else reportMismatch("Rs1E", $sampled(expRs1E), $sampled(Rs1E));
   assert property (@(posedge clk) Rs2E === expRs2E)
      else reportMismatch("Rs2E", $sampled(expRs2E), $sampled(Rs2E));
   assert property (@(posedge clk) RdE === expRdE)
      else reportMismatch("RdE", $sampled(expRdE), $sampled(RdE));
   assert property (@(posedge clk) RegWriteE === expRegWriteE)
      else reportMismatch("RegWriteE", $sampled(expRegWriteE), $sampled(RegWriteE));
   assert property (@(posedge clk) MemWriteE === expMemWriteE)
      else reportMismatch("MemWriteE", $sampled(expMemWriteE), $sampled(MemWriteE));
   assert property (@(posedge clk) JumpE === expJumpE)
      else reportMismatch("JumpE", $sampled(expJumpE), $sampled(JumpE));
   assert property (@(posedge clk) BranchE === expBranchE)
      else reportMismatch("BranchE", $sampled(expBranchE), $sampled(BranchE));
   assert property (@(posedge clk) ALUSrcE === expALUSrcE)
      else reportMismatch("ALUSrcE", $sampled(expALUSrcE), $sampled(ALUSrcE));
   assert property (@(posedge clk) ResultSrcE === expResultSrcE)
      else reportMismatch("ResultSrcE", $sampled(expResultSrcE), $sampled(ResultSrcE));
   assert property (@(posedge clk) ALUControlE === expALUControlE)
      else reportMismatch("ALUControlE", $sampled(expALUControlE), $sampled(ALUControlE));

   assign outputsZero = ~|{RD1E, RD2E, PCE, ImmExtE, PCPlus4E, Rs1E, Rs2E, RdE, RegWriteE,
                           MemWriteE, JumpE, BranchE, ALUSrcE, ResultSrcE, ALUControlE};

   // Pipeline register empty while in reset and on the first edge after it.
   assert property (@(posedge clk) (rst || $fell(rst)) |-> outputsZero)
      else begin
         otherCount++;
         $display("Outputs not all zero during or just after reset at %0t", $time);
      end

   function automatic logic [31:0] nextRand();
      lcgState = lcgState * 32'd1664525 + 32'd1013904223;
      return lcgState;
   endfunction

   function automatic logic [31:0] rTypeWord(logic f7b5, logic [2:0] f3, logic [4:0] rd, rs1, rs2);
      return {1'b0, f7b5, 5'b0, rs2, rs1, f3, rd, 7'b0110011};
   endfunction

   function automatic logic [31:0] iTypeWord(logic [6:0] op, logic [2:0] f3, logic [4:0] rd,
                                             logic [4:0] rs1, logic [11:0] imm);
      return {imm, rs1, f3, rd, op};
   endfunction

   function automatic logic [31:0] storeWord(logic [4:0] rs1, rs2, logic [11:0] imm);
      return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
   endfunction

   function automatic logic [31:0] branchWord(logic [4:0] rs1, rs2, logic [12:0] imm);
      return {imm[12], imm[10:5], rs2, rs1, 3'b000, imm[4:1], imm[11], 7'b1100011};
   endfunction

   function automatic logic [31:0] jalWord(logic [4:0] rd, logic [20:0] imm);
      return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
   endfunction

   // Mostly supported opcodes, with an illegal one now and then.
   function automatic logic [31:0] randomInstr();
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] pick;
      logic [31:0] bits;
      logic [2:0]  f3;
      a = nextRand();
      b = nextRand();
      pick = nextRand();
      bits = {a[31:16], b[31:16]};
      case (pick[28:27])
         2'd0:    f3 = 3'b000;
         2'd1:    f3 = 3'b010;
         2'd2:    f3 = 3'b110;
         default: f3 = 3'b111;
      endcase
      case (pick[31:29])
         3'd0:       bits[6:0] = 7'b0000011;
         3'd1:       bits[6:0] = 7'b0100011;
         3'd2, 3'd6: bits = {1'b0, bits[30], 5'b0, bits[24:15], f3, bits[11:7], 7'b0110011};
         3'd3:       bits = {bits[31:15], f3, bits[11:7], 7'b0010011};
         3'd4:       bits[6:0] = 7'b1100011;
         3'd5:       bits[6:0] = 7'b1101111;
         default:    bits[6:0] = pick[26] ? 7'b1111111 : 7'b0001111;
      endcase
      return bits;
   endfunction

   task automatic waitRise();
      bit seen;
      seen = 1'b0;
      fork
         begin
            @(posedge clk);
            seen = 1'b1;
         end
         #edgeTimeout;
      join_any
      disable fork;
      if (!seen) begin
         $display("No rising clock edge seen within %0t", edgeTimeout);
         $display("TESTS FAILED");
         $finish;
      end
   endtask

   task automatic driveCycle(logic [31:0] instr, logic wEn, logic [4:0] wAddr,
                             logic [31:0] wData);
      waitRise();
      #1;
      InstrD    = instr;
      PCD       = pc;
      PCPlus4D  = pc + 32'd4;
      RegWriteW = wEn;
      RdW       = wAddr;
      ResultW   = wData;
      pc        = pc + 32'd4;
   endtask

   initial begin
      logic [31:0] instr;
      logic [31:0] wData;
      logic [31:0] roll;
      rst           = 1'b1;
      InstrD        = '0;
      PCD           = '0;
      PCPlus4D      = '0;
      ResultW       = '0;
      RegWriteW     = 1'b0;
      RdW           = '0;
      lcgState      = seed;
      pc            = 32'h0000_1000;
      mismatchCount = 0;
      otherCount    = 0;
      for (int i = 0; i < 16; i++) begin
         waitRise();
      end
      #1;
      rst = 1'b0;

      // Same cycle write and read of x5, then x0 ignoring a write.
      driveCycle(rTypeWord(1'b0, 3'b000, 5'd1, 5'd5, 5'd5), 1'b1, 5'd5, 32'h1234_5678);
      driveCycle(rTypeWord(1'b1, 3'b000, 5'd2, 5'd0, 5'd5), 1'b1, 5'd0, 32'hdead_beef);
      driveCycle(rTypeWord(1'b0, 3'b111, 5'd3, 5'd5, 5'd0), 1'b1, 5'd6, 32'h8000_0001);
      driveCycle(rTypeWord(1'b0, 3'b110, 5'd4, 5'd6, 5'd5), 1'b0, 5'd0, '0);
      driveCycle(rTypeWord(1'b0, 3'b010, 5'd7, 5'd6, 5'd0), 1'b0, 5'd0, '0);
      // I type with negative immediates and bit 30 set on addi.
      driveCycle(iTypeWord(7'b0010011, 3'b000, 5'd8, 5'd5, 12'hffb), 1'b0, 5'd0, '0);
      driveCycle(iTypeWord(7'b0010011, 3'b000, 5'd8, 5'd5, 12'h400), 1'b0, 5'd0, '0);
      driveCycle(iTypeWord(7'b0010011, 3'b111, 5'd9, 5'd6, 12'h0f0), 1'b0, 5'd0, '0);
      driveCycle(iTypeWord(7'b0010011, 3'b110, 5'd9, 5'd6, 12'h800), 1'b0, 5'd0, '0);
      driveCycle(iTypeWord(7'b0010011, 3'b010, 5'd9, 5'd6, 12'hfff), 1'b0, 5'd0, '0);
      driveCycle(iTypeWord(7'b0000011, 3'b010, 5'd10, 5'd6, 12'hff0), 1'b0, 5'd0, '0);
      driveCycle(storeWord(5'd6, 5'd5, 12'hff8), 1'b0, 5'd0, '0);
      driveCycle(branchWord(5'd5, 5'd6, 13'h1ff8), 1'b0, 5'd0, '0);
      driveCycle(branchWord(5'd5, 5'd6, 13'h0010), 1'b0, 5'd0, '0);
      driveCycle(jalWord(5'd1, 21'h1ff800), 1'b0, 5'd0, '0);
      driveCycle(jalWord(5'd1, 21'h007ffe), 1'b0, 5'd0, '0);
      driveCycle(32'hffff_ffff, 1'b0, 5'd0, '0);

      for (int i = 0; i < randomCount; i++) begin
         instr = randomInstr();
         wData = nextRand();
         roll  = nextRand();
         // Now and then read the register being written in the same cycle.
         if (roll[31:30] == 2'b00) begin
            instr[19:15] = roll[27:23];
         end
         driveCycle(instr, roll[29], roll[27:23], wData);
      end

      waitRise();
      waitRise();
      #1;
      $display("Value mismatches: %0d, other failures: %0d", mismatchCount, otherCount);
      if (mismatchCount == 0 && otherCount == 0) begin
         $display("TESTS PASSED");
      end else begin
         $display("TESTS FAILED");
      end
      $finish;
   end

endmodule

/* bench/decodeGolden.sv */
module decodeGolden (
   input  logic        clk,
   input  logic        rst,
   input  logic [31:0] InstrD,
   input  logic [31:0] PCD,
   input  logic [31:0] PCPlus4D,
   input  logic [31:0] ResultW,
   input  logic        RegWriteW,
   input  logic [4:0]  RdW,
   output logic [31:0] expRD1E,
   output logic [31:0] expRD2E,
   output logic [31:0] expPCE,
   output logic [31:0] expImmExtE,
   output logic [31:0] expPCPlus4E,
   output logic [4:0]  expRs1E,
   output logic [4:0]  expRs2E,
   output logic [4:0]  expRdE,
   output logic        expRegWriteE,
   output logic        expMemWriteE,
   output logic        expJumpE,
   output logic        expBranchE,
   output logic        expALUSrcE,
   output logic [1:0]  expResultSrcE,
   output logic [2:0]  expALUControlE
);
   timeunit 1ns;
   timeprecision 100ps;

   logic [31:0] shadow [32];
   logic [11:0] ctlD;

   // Arithmetic code from funct3; only R type may subtract.
   function automatic logic [2:0] aluFromFunct3(logic [2:0] f3, logic subtract);
      case (f3)
         3'b000:  return subtract ? 3'b001 : 3'b000;
         3'b010:  return 3'b101;
         3'b110:  return 3'b011;
         3'b111:  return 3'b010;
         default: return 3'b000;
      endcase
   endfunction

   // {regWrite, resultSrc, memWrite, jump, branch, aluSrc, immSrc, aluControl}.
   function automatic logic [11:0] controlVector(logic [31:0] instr);
      case (instr[6:0])
         7'b0000011: return {1'b1, 2'b01, 3'b000, 1'b1, 2'b00, 3'b000};
         7'b0100011: return {1'b0, 2'b00, 3'b100, 1'b1, 2'b01, 3'b000};
         7'b0110011: return {1'b1, 2'b00, 4'b0000, 2'b00, aluFromFunct3(instr[14:12], instr[30])};
         7'b0010011: return {1'b1, 2'b00, 3'b000, 1'b1, 2'b00, aluFromFunct3(instr[14:12], 1'b0)};
         7'b1100011: return {1'b0, 2'b00, 3'b001, 1'b0, 2'b10, 3'b001};
         7'b1101111: return {1'b1, 2'b10, 3'b010, 1'b0, 2'b11, 3'b000};
         default:    return '0;
      endcase
   endfunction

   function automatic logic [31:0] immediateOf(logic [31:0] instr, logic [1:0] sel);
      case (sel)
         2'b00:   return {{20{instr[31]}}, instr[31:20]};
         2'b01:   return {{20{instr[31]}}, instr[31:25], instr[11:7]};
         2'b10:   return {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
         default: return {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
      endcase
   endfunction

   function automatic logic [31:0] readShadow(logic [4:0] addr);
      return (addr == 5'd0) ? 32'd0 : shadow[addr];
   endfunction

   // Shadow registers follow the writeback port on the falling edge.
   always_ff @(negedge clk or posedge rst) begin
      if (rst) begin
         for (int i = 0; i < 32; i++) begin
            shadow[i] <= '0;
         end
      end else if (RegWriteW && (RdW != 5'd0)) begin
         shadow[RdW] <= ResultW;
      end
   end

   assign ctlD = controlVector(InstrD);

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         {expRD1E, expRD2E, expPCE, expImmExtE, expPCPlus4E, expRs1E, expRs2E, expRdE,
          expRegWriteE, expMemWriteE, expJumpE, expBranchE, expALUSrcE, expResultSrcE,
          expALUControlE} <= '0;
      end else begin
         expRD1E        <= readShadow(InstrD[19:15]);
         expRD2E        <= readShadow(InstrD[24:20]);
         expPCE         <= PCD;
         expPCPlus4E    <= PCPlus4D;
         expImmExtE     <= immediateOf(InstrD, ctlD[4:3]);
         expRs1E        <= InstrD[19:15];
         expRs2E        <= InstrD[24:20];
         expRdE         <= InstrD[11:7];
         expRegWriteE   <= ctlD[11];
         expResultSrcE  <= ctlD[10:9];
         expMemWriteE   <= ctlD[8];
         expJumpE       <= ctlD[7];
         expBranchE     <= ctlD[6];
         expALUSrcE     <= ctlD[5];
         expALUControlE <= ctlD[2:0];
      end
   end

endmodule

/* hdl/decodeStage.sv */
module decodeStage import decodePkg::*; (
   input  logic                   clk,
   input  logic                   rst,
   input  logic [wordSize-1:0]    InstrD,
   input  logic [wordSize-1:0]    PCD,
   input  logic [wordSize-1:0]    PCPlus4D,
   input  logic [wordSize-1:0]    ResultW,
   input  logic                   RegWriteW,
   input  logic [regAddrBits-1:0] RdW,

   output logic [wordSize-1:0]    RD1E,
   output logic [wordSize-1:0]    RD2E,
   output logic [wordSize-1:0]    PCE,
   output logic [wordSize-1:0]    ImmExtE,
   output logic [wordSize-1:0]    PCPlus4E,
   output logic [regAddrBits-1:0] Rs1E,
   output logic [regAddrBits-1:0] Rs2E,
   output logic [regAddrBits-1:0] RdE,
   output logic                   RegWriteE,
   output logic                   MemWriteE,
   output logic                   JumpE,
   output logic                   BranchE,
   output logic                   ALUSrcE,
   output logic [1:0]             ResultSrcE,
   output logic [2:0]             ALUControlE
);

   instrWord            instrView;
   logic [wordSize-1:0] rd1D;
   logic [wordSize-1:0] rd2D;
   logic [wordSize-1:0] immExtD;

   // Decoded controls.
   logic       regWriteD;
   logic       memWriteD;
   logic       jumpD;
   logic       branchD;
   logic       aluSrcD;
   logic [1:0] resultSrcD;
   logic [1:0] immSrcD;
   logic [2:0] aluControlD;

   assign instrView = InstrD;

   registerFile regFile0 (
      .clk       (clk),
      .rst       (rst),
      .readAddr1 (instrView.fields.rs1),
      .readAddr2 (instrView.fields.rs2),
      .writeEn   (RegWriteW),
      .writeAddr (RdW),
      .writeData (ResultW),
      .readData1 (rd1D),
      .readData2 (rd2D)
   );

   controlUnit ctrl0 (
      .op         (instrView.fields.opcode),
      .funct3     (instrView.fields.funct3),
      .funct7b5   (instrView.fields.funct7[5]),
      .regWrite   (regWriteD),
      .resultSrc  (resultSrcD),
      .memWrite   (memWriteD),
      .jump       (jumpD),
      .branch     (branchD),
      .aluSrc     (aluSrcD),
      .immSrc     (immSrcD),
      .aluControl (aluControlD)
   );

   immExtender immExt0 (
      .instr  (instrView),
      .immSrc (immSrcD),
      .immExt (immExtD)
   );

   // Decode to execute register, loaded every cycle.
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         RD1E        <= '0;
         RD2E        <= '0;
         PCE         <= '0;
         PCPlus4E    <= '0;
         ImmExtE     <= '0;
         Rs1E        <= '0;
         Rs2E        <= '0;
         RdE         <= '0;
         RegWriteE   <= 1'b0;
         MemWriteE   <= 1'b0;
         JumpE       <= 1'b0;
         BranchE     <= 1'b0;
         ALUSrcE     <= 1'b0;
         ResultSrcE  <= '0;
         ALUControlE <= '0;
      end else begin
         RD1E        <= rd1D;
         RD2E        <= rd2D;
         PCE         <= PCD;
         PCPlus4E    <= PCPlus4D;
         ImmExtE     <= immExtD;
         Rs1E        <= instrView.fields.rs1;
         Rs2E        <= instrView.fields.rs2;
         RdE         <= instrView.fields.rd;
         RegWriteE   <= regWriteD;
         MemWriteE   <= memWriteD;
         JumpE       <= jumpD;
         BranchE     <= branchD;
         ALUSrcE     <= aluSrcD;
         ResultSrcE  <= resultSrcD;
         ALUControlE <= aluControlD;
      end
   end

   // Execute stage must see a bubble right after reset release.
   assert property (@(posedge clk) $fell(rst) |->
         !RegWriteE && !MemWriteE && !JumpE && !BranchE && !ALUSrcE &&
         (ResultSrcE == '0) && (ALUControlE == '0))
      else $error("decodeStage: control outputs not cleared after reset");

endmodule

/* hdl/registerFile.sv */
module registerFile import decodePkg::*; (
   input  logic                   clk,
   input  logic                   rst,
   input  logic [regAddrBits-1:0] readAddr1,
   input  logic [regAddrBits-1:0] readAddr2,
   input  logic                   writeEn,
   input  logic [regAddrBits-1:0] writeAddr,
   input  logic [wordSize-1:0]    writeData,
   output logic [wordSize-1:0]    readData1,
   output logic [wordSize-1:0]    readData2
);

   logic [wordSize-1:0] regs [numRegs];

   // Writes land on the falling edge so that decode sees them in the same cycle.
   always_ff @(negedge clk or posedge rst) begin
      if (rst) begin
         for (int i = 0; i < numRegs; i++) begin
            regs[i] <= '0;
         end
      end else if (writeEn && (writeAddr != '0)) begin
         regs[writeAddr] <= writeData;
      end
   end

   // Combinational reads.
   // x0 stays zero because writes to it are dropped.
   assign readData1 = regs[readAddr1];
   assign readData2 = regs[readAddr2];

   // Reads from x0 give zero on both ports even after a write to it.
   property pX0Zero;
      @(posedge clk) disable iff (rst)
         ((readAddr1 != '0) || (readData1 == '0)) &&
         ((readAddr2 != '0) || (readData2 == '0));
   endproperty

   assert property (pX0Zero)
      else $error("registerFile: nonzero read from x0");

endmodule

/* hdl/immExtender.sv */
module immExtender import decodePkg::*; (
   input  instrWord              instr,
   input  logic [1:0]            immSrc,
   output logic [wordSize-1:0]   immExt
);

   logic        sign;
   logic [10:0] hi;
   logic [7:0]  mid;
   logic [4:0]  lo;

   // Raw immediate bits of the instruction.
   assign sign = instr.imm.sign;
   assign hi   = instr.imm.hi;
   assign mid  = instr.imm.mid;
   assign lo   = instr.imm.lo;

   always_comb begin
      case (immSrc)
         // I type, bits 31:20.
         immI: immExt = {{21{sign}}, hi};
         // S type, bits 31:25 and 11:7.
         immS: immExt = {{21{sign}}, hi[10:5], lo};
         // B type, halfword aligned.
         immB: immExt = {{20{sign}}, lo[0], hi[10:5], lo[4:1], 1'b0};
         // J type, halfword aligned.
         immJ: immExt = {{12{sign}}, mid, hi[0], hi[10:1], 1'b0};
         default: immExt = '0;
      endcase
   end

endmodule

/* hdl/controlUnit.sv */
module controlUnit import decodePkg::*; (
   input  logic [6:0] op,
   input  logic [2:0] funct3,
   input  logic       funct7b5,
   output logic       regWrite,
   output logic [1:0] resultSrc,
   output logic       memWrite,
   output logic       jump,
   output logic       branch,
   output logic       aluSrc,
   output logic [1:0] immSrc,
   output logic [2:0] aluControl
);

   logic [1:0] aluOp;
   logic       rTypeSub;

   // Main decoder.
   always_comb begin
      regWrite  = 1'b0;
      resultSrc = resAlu;
      memWrite  = 1'b0;
      jump      = 1'b0;
      branch    = 1'b0;
      aluSrc    = 1'b0;
      immSrc    = immI;
      aluOp     = aluOpAdd;
      case (op)
         opLoad: begin
            regWrite  = 1'b1;
            resultSrc = resMem;
            aluSrc    = 1'b1;
            immSrc    = immI;
         end
         opStore: begin
            memWrite = 1'b1;
            aluSrc   = 1'b1;
            immSrc   = immS;
         end
         opRType: begin
            regWrite = 1'b1;
            aluOp    = aluOpFunct;
         end
         opIType: begin
            regWrite = 1'b1;
            aluSrc   = 1'b1;
            immSrc   = immI;
            aluOp    = aluOpFunct;
         end
         opBranch: begin
            branch = 1'b1;
            immSrc = immB;
            aluOp  = aluOpSub;
         end
         opJal: begin
            regWrite  = 1'b1;
            resultSrc = resPc4;
            jump      = 1'b1;
            immSrc    = immJ;
         end
         default: begin
            // Unknown opcode leaves every control low.
            regWrite = 1'b0;
         end
      endcase
   end

   // Only R-type with funct7 bit 5 set subtracts; addi never does.
   assign rTypeSub = funct7b5 & op[5];

   // ALU decoder.
   always_comb begin
      aluControl = aluAdd;
      case (aluOp)
         aluOpAdd: aluControl = aluAdd;
         aluOpSub: aluControl = aluSub;
         aluOpFunct: begin
            case (funct3)
               f3AddSub: aluControl = rTypeSub ? aluSub : aluAdd;
               f3Slt:    aluControl = aluSlt;
               f3Or:     aluControl = aluOr;
               f3And:    aluControl = aluAnd;
               default:  aluControl = aluAdd;
            endcase
         end
         default: aluControl = aluAdd;
      endcase
   end

   // No instruction both stores to memory and writes a register.
   always_comb begin
      assert final (!(memWrite && regWrite))
         else $error("controlUnit: memWrite and regWrite both set, op %b", op);
   end

endmodule

/* hdl/decodePkg.sv */
package decodePkg;

   // Datapath and register file geometry.
   localparam int wordSize    = 32;
   localparam int regAddrBits = 5;
   localparam int numRegs     = 32;

   // Major opcodes of the supported instructions.
   localparam logic [6:0] opLoad   = 7'b0000011;
   localparam logic [6:0] opStore  = 7'b0100011;
   localparam logic [6:0] opRType  = 7'b0110011;
   localparam logic [6:0] opIType  = 7'b0010011;
   localparam logic [6:0] opBranch = 7'b1100011;
   localparam logic [6:0] opJal    = 7'b1101111;

   // Function codes for R and I type arithmetic.
   localparam logic [2:0] f3AddSub = 3'b000;
   localparam logic [2:0] f3Slt    = 3'b010;
   localparam logic [2:0] f3Or     = 3'b110;
   localparam logic [2:0] f3And    = 3'b111;

   // Immediate format selectors.
   localparam logic [1:0] immI = 2'b00;
   localparam logic [1:0] immS = 2'b01;
   localparam logic [1:0] immB = 2'b10;
   localparam logic [1:0] immJ = 2'b11;

   // Writeback result selectors.
   localparam logic [1:0] resAlu = 2'b00;
   localparam logic [1:0] resMem = 2'b01;
   localparam logic [1:0] resPc4 = 2'b10;

   // ALU operation codes.
   localparam logic [2:0] aluAdd = 3'b000;
   localparam logic [2:0] aluSub = 3'b001;
   localparam logic [2:0] aluAnd = 3'b010;
   localparam logic [2:0] aluOr  = 3'b011;
   localparam logic [2:0] aluSlt = 3'b101;

   // Operation class from the main decoder to the ALU decoder.
   localparam logic [1:0] aluOpAdd   = 2'b00;
   localparam logic [1:0] aluOpSub   = 2'b01;
   localparam logic [1:0] aluOpFunct = 2'b10;

   // Instruction word, seen as register fields or as raw immediate bits.
   typedef union packed {
      struct packed {
         logic [6:0] funct7;
         logic [4:0] rs2;
         logic [4:0] rs1;
         logic [2:0] funct3;
         logic [4:0] rd;
         logic [6:0] opcode;
      } fields;
      struct packed {
         logic        sign;   // Bit 31.
         logic [10:0] hi;     // Bits 30:20.
         logic [7:0]  mid;    // Bits 19:12.
         logic [4:0]  lo;     // Bits 11:7.
         logic [6:0]  opcode;
      } imm;
   } instrWord;

endpackage
